//--- flist.f
+incdir+tb
common/uart_buf_pkg.sv
uart_buffer/rx_byte_store.sv
uart_buffer/rx_poller.sv
uart_buffer/cpu_read_port.sv
uart_buffer/uart_read_arbiter.sv
src/uart_rx_regs.sv
src/uart_subsys_top.sv
tb/tb_uart_subsys.sv

//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_uart_subsys
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/tb_vectors.svh
`ifndef tb_vectors_svh
`define tb_vectors_svh

typedef enum logic [1:0] {
   op_inject,
   op_read,
   op_write,
   op_idle
} op_t;

// count is bytes, reads or idle cycles and gap is cycles per injected byte
typedef struct packed {
   op_t         op;
   logic [3:0]  addr;
   logic [7:0]  count;
   logic [7:0]  gap;
   logic [31:0] data;
   logic [31:0] exp_data;
   logic [31:0] mask;
   logic [1:0]  exp_resp;
} vec_t;

localparam logic [3:0] reg_rx   = uart_buf_pkg::addr_rx;
localparam logic [3:0] reg_tx   = uart_buf_pkg::addr_tx;
localparam logic [3:0] reg_stat = uart_buf_pkg::addr_stat;
localparam logic [1:0] ok       = uart_buf_pkg::resp_okay;
localparam logic [1:0] err      = uart_buf_pkg::resp_slverr;

localparam int n_vectors = 22;

// rx reads expect exp_data + n for the n-th read of an entry
localparam vec_t vectors [n_vectors] = '{
   '{op_idle,   reg_rx,   8'd4,  8'd0, 32'h00,       32'h00, 32'h00000000, ok},
   '{op_read,   reg_stat, 8'd1,  8'd0, 32'h00,       32'h00, 32'h00000021, ok},
   '{op_read,   reg_rx,   8'd1,  8'd0, 32'h00,       32'h00, 32'hffffffff, err},
   '{op_inject, reg_rx,   8'd3,  8'd4, 32'h10,       32'h00, 32'h00000000, ok},
   '{op_read,   reg_rx,   8'd3,  8'd0, 32'h00,       32'h10, 32'hffffffff, ok},
   '{op_read,   reg_stat, 8'd1,  8'd0, 32'h00,       32'h00, 32'h00000021, ok},
   '{op_inject, reg_rx,   8'd1,  8'd1, 32'h20,       32'h00, 32'h00000000, ok},
   '{op_read,   reg_rx,   8'd1,  8'd0, 32'h00,       32'h20, 32'hffffffff, ok},
   '{op_read,   reg_stat, 8'd1,  8'd0, 32'h00,       32'h00, 32'h00000021, ok},
   '{op_write,  reg_tx,   8'd1,  8'd0, 32'h0000005a, 32'h5a, 32'h00000000, ok},
   '{op_write,  reg_tx,   8'd1,  8'd0, 32'h123456c3, 32'hc3, 32'h00000000, ok},
   '{op_inject, reg_rx,   8'd2,  8'd4, 32'h30,       32'h00, 32'h00000000, ok},
   '{op_read,   reg_stat, 8'd1,  8'd0, 32'h00,       32'h01, 32'h00000021, ok},
   '{op_read,   reg_rx,   8'd2,  8'd0, 32'h00,       32'h30, 32'hffffffff, ok},
   // fill store and uart fifo to the brim
   '{op_inject, reg_rx,   8'd20, 8'd4, 32'h40,       32'h00, 32'h00000000, ok},
   '{op_inject, reg_rx,   8'd3,  8'd1, 32'h80,       32'h00, 32'h00000000, ok},
   '{op_read,   reg_stat, 8'd1,  8'd0, 32'h00,       32'h21, 32'h00000021, ok},
   '{op_read,   reg_stat, 8'd1,  8'd0, 32'h00,       32'h01, 32'h00000021, ok},
   '{op_read,   reg_rx,   8'd20, 8'd0, 32'h00,       32'h40, 32'hffffffff, ok},
   '{op_read,   reg_stat, 8'd1,  8'd0, 32'h00,       32'h00, 32'h00000021, ok},
   '{op_read,   reg_rx,   8'd1,  8'd0, 32'h00,       32'h00, 32'hffffffff, err},
   '{op_idle,   reg_rx,   8'd4,  8'd0, 32'h00,       32'h00, 32'h00000000, ok}
};

`endif

//--- tb/tb_uart_subsys.sv
module tb_uart_subsys;

   localparam int store_depth   = 16;
   localparam int rx_fifo_depth = 4;

   `include "tb_vectors.svh"

   logic                   clk;
   logic                   rstn;
   uart_buf_pkg::rd_addr_t cpu_ar;
   logic                   cpu_arvalid;
   logic                   cpu_arready;
   uart_buf_pkg::rd_data_t cpu_r;
   logic                   cpu_rvalid;
   logic                   cpu_rready;
   uart_buf_pkg::wr_req_t  cpu_w;
   logic                   cpu_wvalid;
   logic                   cpu_wready;
   logic [1:0]             cpu_bresp;
   logic                   cpu_bvalid;
   logic                   cpu_bready;
   logic [7:0]             rx_byte;
   logic                   rx_strobe;
   logic [7:0]             tx_byte;
   logic                   tx_strobe;

   uart_buf_pkg::rd_data_t read_word;
   logic [1:0]             write_resp;
   logic [15:0]            lfsr = 16'd33;
   int                     tx_count = 0;
   logic [7:0]             tx_last = 8'h00;
   int                     rd_errors = 0;
   int                     wr_errors = 0;
   int                     misc_errors = 0;
   int                     cycles = 0;
   int                     limit = 100;

   uart_subsys_top #(
      .store_depth(store_depth),
      .rx_fifo_depth(rx_fifo_depth)
   ) dut0 (
      .clk(clk), .rstn(rstn),
      .cpu_ar(cpu_ar), .cpu_arvalid(cpu_arvalid), .cpu_arready(cpu_arready),
      .cpu_r(cpu_r), .cpu_rvalid(cpu_rvalid), .cpu_rready(cpu_rready),
      .cpu_w(cpu_w), .cpu_wvalid(cpu_wvalid), .cpu_wready(cpu_wready),
      .cpu_bresp(cpu_bresp), .cpu_bvalid(cpu_bvalid), .cpu_bready(cpu_bready),
      .rx_byte(rx_byte), .rx_strobe(rx_strobe),
      .tx_byte(tx_byte), .tx_strobe(tx_strobe)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("run stopped after %0d cycles before the table was done", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // count tx pulses and keep the last byte
   always @(negedge clk) begin
      if (tx_strobe) begin
         tx_count <= tx_count + 1;
         tx_last  <= tx_byte;
      end
   end

   //////////////////////////////////////////////////
   // random stalls
   //////////////////////////////////////////////////

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   task automatic random_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b = lfsr[0];
   endtask

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   task automatic compare_read(input uart_buf_pkg::rd_data_t got,
                               input uart_buf_pkg::rd_data_t exp,
                               input logic [31:0] mask);
      if ((got.data & mask) !== (exp.data & mask)) begin
         rd_errors++;
         $display("error cpu_r.data got %h expected %h mask %h",
                  got.data & mask, exp.data & mask, mask);
      end
      if (got.resp !== exp.resp) begin
         rd_errors++;
         $display("error cpu_r.resp got %h expected %h", got.resp, exp.resp);
      end
   endtask

   task automatic compare_write(input logic [1:0] got_resp, input logic [1:0] exp_resp,
                                input logic [7:0] got_tx, input logic [7:0] exp_tx);
      if (got_resp !== exp_resp) begin
         wr_errors++;
         $display("error cpu_bresp got %h expected %h", got_resp, exp_resp);
      end
      if (got_tx !== exp_tx) begin
         wr_errors++;
         $display("error tx_byte got %h expected %h", got_tx, exp_tx);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         misc_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   //////////////////////////////////////////////////
   // bus driver tasks start on a rising edge
   //////////////////////////////////////////////////

   task automatic inject_bytes(input logic [7:0] first, input int n, input int gap);
      for (int k = 0; k < n; k++) begin
         if (k != 0) begin
            @(posedge clk);
         end
         rx_byte   <= first + 8'(k);
         rx_strobe <= 1'b1;
         repeat (gap - 1) begin
            @(posedge clk);
            rx_strobe <= 1'b0;
         end
      end
   endtask

   task automatic cpu_read(input logic [3:0] addr);
      logic done;
      logic b;
      cpu_ar      <= '{addr: addr, prot: 3'b000};
      cpu_arvalid <= 1'b1;
      random_bit(b);
      cpu_rready  <= b;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = cpu_arready;
         @(posedge clk);
      end
      cpu_arvalid <= 1'b0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (cpu_rvalid && cpu_rready) begin
            read_word = cpu_r;
            done = 1'b1;
         end
         @(posedge clk);
         random_bit(b);
         cpu_rready <= b && !done;
      end
   endtask

   task automatic cpu_write(input logic [3:0] addr, input logic [31:0] data);
      logic done;
      logic b;
      cpu_w      <= '{addr: addr, prot: 3'b000, data: data, strb: 4'hf};
      cpu_wvalid <= 1'b1;
      random_bit(b);
      cpu_bready <= b;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = cpu_wready;
         @(posedge clk);
      end
      cpu_wvalid <= 1'b0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (cpu_bvalid && cpu_bready) begin
            write_resp = cpu_bresp;
            done = 1'b1;
         end
         @(posedge clk);
         random_bit(b);
         cpu_bready <= b && !done;
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      uart_buf_pkg::rd_data_t exp;
      vec_t v;
      int tx_before;
      for (int i = 0; i < n_vectors; i++) begin
         limit += 40 * int'(vectors[i].count);
      end
      rstn        = 1'b1;
      cpu_ar      = '0;
      cpu_arvalid = 1'b0;
      cpu_rready  = 1'b0;
      cpu_w       = '0;
      cpu_wvalid  = 1'b0;
      cpu_bready  = 1'b0;
      rx_byte     = 8'h00;
      rx_strobe   = 1'b0;
      repeat (2) @(posedge clk);
      rstn <= 1'b0;
      @(negedge clk);
      check_flag("cpu_rvalid", cpu_rvalid, 1'b0);
      check_flag("cpu_bvalid", cpu_bvalid, 1'b0);
      check_flag("tx_strobe", tx_strobe, 1'b0);
      check_flag("cpu_arready", cpu_arready, 1'b1);

      for (int i = 0; i < n_vectors; i++) begin
         v = vectors[i];
         @(posedge clk);
         rx_strobe <= 1'b0;
         case (v.op)
            op_inject: inject_bytes(v.data[7:0], int'(v.count), int'(v.gap));
            op_read: begin
               for (int k = 0; k < int'(v.count); k++) begin
                  cpu_read(v.addr);
                  exp.data = v.exp_data + 32'(k);
                  exp.resp = v.exp_resp;
                  compare_read(read_word, exp, v.mask);
               end
            end
            op_write: begin
               tx_before = tx_count;
               cpu_write(v.addr, v.data);
               compare_write(write_resp, v.exp_resp, tx_last, v.exp_data[7:0]);
               if (tx_count - tx_before != 1) begin
                  misc_errors++;
                  $display("write to the tx register gave %0d strobes instead of one",
                           tx_count - tx_before);
               end
            end
            default: repeat (int'(v.count) - 1) @(posedge clk);
         endcase
      end

      $display("summary: %0d read errors, %0d write errors, %0d other errors",
               rd_errors, wr_errors, misc_errors);
      if (rd_errors + wr_errors + misc_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- src/uart_subsys_top.sv
module uart_subsys_top #(
   parameter int store_depth   = 16,
   parameter int rx_fifo_depth = 4
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  uart_buf_pkg::rd_addr_t cpu_ar,
   input  logic                   cpu_arvalid,
   output logic                   cpu_arready,
   output uart_buf_pkg::rd_data_t cpu_r,
   output logic                   cpu_rvalid,
   input  logic                   cpu_rready,
   input  uart_buf_pkg::wr_req_t  cpu_w,
   input  logic                   cpu_wvalid,
   output logic                   cpu_wready,
   output logic [1:0]             cpu_bresp,
   output logic                   cpu_bvalid,
   input  logic                   cpu_bready,
   input  logic [7:0]             rx_byte,
   input  logic                   rx_strobe,
   output logic [7:0]             tx_byte,
   output logic                   tx_strobe
);
   // cpu port to arbiter
   uart_buf_pkg::rd_addr_t cpu_req;
   uart_buf_pkg::rd_data_t cpu_rsp;
   logic                   cpu_req_valid;
   logic                   cpu_req_ready;
   logic                   cpu_rsp_valid;
   logic                   cpu_rsp_ready;
   // poller to arbiter
   uart_buf_pkg::rd_addr_t poll_req;
   uart_buf_pkg::rd_data_t poll_rsp;
   logic                   poll_req_valid;
   logic                   poll_req_ready;
   logic                   poll_rsp_valid;
   logic                   poll_rsp_ready;
   // arbiter to uart
   uart_buf_pkg::rd_addr_t uart_ar;
   uart_buf_pkg::rd_data_t uart_r;
   logic                   uart_arvalid;
   logic                   uart_arready;
   logic                   uart_rvalid;
   logic                   uart_rready;
   // byte store
   logic                   push_en;
   logic [7:0]             push_byte;
   logic                   pop_en;
   logic [7:0]             head_byte;
   logic                   empty;
   logic                   full;
   logic                   cpu_busy;

   rx_byte_store #(.store_depth(store_depth)) store0 (
      .clk(clk), .rstn(rstn), .push_en(push_en), .pop_en(pop_en),
      .push_byte(push_byte), .head_byte(head_byte), .empty(empty), .full(full)
   );

   rx_poller poller0 (
      .clk(clk), .rstn(rstn), .full(full), .cpu_busy(cpu_busy),
      .req(poll_req), .req_valid(poll_req_valid), .req_ready(poll_req_ready),
      .rsp(poll_rsp), .rsp_valid(poll_rsp_valid), .rsp_ready(poll_rsp_ready),
      .push_en(push_en), .push_byte(push_byte)
   );

   cpu_read_port cpu_port0 (
      .clk(clk), .rstn(rstn),
      .cpu_ar(cpu_ar), .cpu_arvalid(cpu_arvalid), .cpu_arready(cpu_arready),
      .cpu_r(cpu_r), .cpu_rvalid(cpu_rvalid), .cpu_rready(cpu_rready),
      .req(cpu_req), .req_valid(cpu_req_valid), .req_ready(cpu_req_ready),
      .rsp(cpu_rsp), .rsp_valid(cpu_rsp_valid), .rsp_ready(cpu_rsp_ready),
      .empty(empty), .head_byte(head_byte), .pop_en(pop_en), .busy(cpu_busy)
   );

   uart_read_arbiter arb0 (
      .clk(clk), .rstn(rstn),
      .cpu_req(cpu_req), .cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready),
      .cpu_rsp(cpu_rsp), .cpu_rsp_valid(cpu_rsp_valid), .cpu_rsp_ready(cpu_rsp_ready),
      .poll_req(poll_req), .poll_req_valid(poll_req_valid),
      .poll_req_ready(poll_req_ready), .poll_rsp(poll_rsp),
      .poll_rsp_valid(poll_rsp_valid), .poll_rsp_ready(poll_rsp_ready),
      .uart_ar(uart_ar), .uart_arvalid(uart_arvalid), .uart_arready(uart_arready),
      .uart_r(uart_r), .uart_rvalid(uart_rvalid), .uart_rready(uart_rready)
   );

   uart_rx_regs #(.rx_fifo_depth(rx_fifo_depth)) uart0 (
      .clk(clk), .rstn(rstn),
      .ar(uart_ar), .arvalid(uart_arvalid), .arready(uart_arready),
      .r(uart_r), .rvalid(uart_rvalid), .rready(uart_rready),
      .w(cpu_w), .wvalid(cpu_wvalid), .wready(cpu_wready),
      .bresp(cpu_bresp), .bvalid(cpu_bvalid), .bready(cpu_bready),
      .rx_byte(rx_byte), .rx_strobe(rx_strobe),
      .tx_byte(tx_byte), .tx_strobe(tx_strobe)
   );

endmodule

//--- src/uart_rx_regs.sv
module uart_rx_regs #(
   parameter int rx_fifo_depth = 4
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  uart_buf_pkg::rd_addr_t ar,
   input  logic                   arvalid,
   output logic                   arready,
   output uart_buf_pkg::rd_data_t r,
   output logic                   rvalid,
   input  logic                   rready,
   input  uart_buf_pkg::wr_req_t  w,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [7:0]             rx_byte,
   input  logic                   rx_strobe,
   output logic [7:0]             tx_byte,
   output logic                   tx_strobe
);
   localparam int ptr_w = $clog2(rx_fifo_depth);
   localparam int cnt_w = $clog2(rx_fifo_depth + 1);

   logic [7:0]               fifo [rx_fifo_depth];
   logic [ptr_w-1:0]         wr_ptr;
   logic [ptr_w-1:0]         rd_ptr;
   logic [cnt_w-1:0]         count;
   logic                     overrun;
   logic                     ar_fire;
   logic                     w_fire;
   logic                     rx_push;
   logic                     rx_pop;
   uart_buf_pkg::uart_word_u stat_word;

   assign arready = !rvalid;
   assign wready  = !bvalid;
   assign ar_fire = arvalid && arready;
   assign w_fire  = wvalid && wready;
   assign rx_push = rx_strobe && (count != cnt_w'(rx_fifo_depth));
   assign rx_pop  = ar_fire && (ar.addr == uart_buf_pkg::addr_rx) && (count != '0);

   // tx leaves at once, so it never fills
   always_comb begin
      stat_word               = '0;
      stat_word.stat.overrun  = overrun;
      stat_word.stat.tx_empty = 1'b1;
      stat_word.stat.rx_full  = (count == cnt_w'(rx_fifo_depth));
      stat_word.stat.rx_valid = (count != '0);
   end

   //////////////////////////////////////////////////
   // receive fifo
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rx_push) begin
         fifo[wr_ptr] <= rx_byte;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         overrun <= 1'b0;
      end else begin
         if (rx_push) begin
            wr_ptr <= (wr_ptr == ptr_w'(rx_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rx_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(rx_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({rx_push, rx_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // a fresh drop wins over the clearing read
         if (rx_strobe && !rx_push) begin
            overrun <= 1'b1;
         end else if (ar_fire && (ar.addr == uart_buf_pkg::addr_stat)) begin
            overrun <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////
   // read and write channels
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         rvalid    <= 1'b0;
         bvalid    <= 1'b0;
         tx_strobe <= 1'b0;
      end else begin
         if (ar_fire) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         if (w_fire) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         tx_strobe <= w_fire && (w.addr == uart_buf_pkg::addr_tx) && w.strb[0];
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         case (ar.addr)
            uart_buf_pkg::addr_rx: begin
               if (rx_pop) begin
                  r <= {24'h000000, fifo[rd_ptr], uart_buf_pkg::resp_okay};
               end else begin
                  r <= {32'h0, uart_buf_pkg::resp_slverr};
               end
            end
            uart_buf_pkg::addr_stat: r <= {stat_word, uart_buf_pkg::resp_okay};
            uart_buf_pkg::addr_tx:   r <= {32'h0, uart_buf_pkg::resp_okay};
            default:                 r <= {32'h0, uart_buf_pkg::resp_slverr};
         endcase
      end
      if (w_fire) begin
         bresp <= (w.addr == uart_buf_pkg::addr_tx) ? uart_buf_pkg::resp_okay
                                                     : uart_buf_pkg::resp_slverr;
         tx_byte <= w.data[7:0];
      end
   end

   a_tx_pulse: assert property (@(posedge clk) disable iff (rstn)
      tx_strobe |=> !tx_strobe);

endmodule

//--- uart_buffer/uart_read_arbiter.sv
module uart_read_arbiter (
   input  logic                   clk,
   input  logic                   rstn,
   input  uart_buf_pkg::rd_addr_t cpu_req,
   input  logic                   cpu_req_valid,
   output logic                   cpu_req_ready,
   output uart_buf_pkg::rd_data_t cpu_rsp,
   output logic                   cpu_rsp_valid,
   input  logic                   cpu_rsp_ready,
   input  uart_buf_pkg::rd_addr_t poll_req,
   input  logic                   poll_req_valid,
   output logic                   poll_req_ready,
   output uart_buf_pkg::rd_data_t poll_rsp,
   output logic                   poll_rsp_valid,
   input  logic                   poll_rsp_ready,
   output uart_buf_pkg::rd_addr_t uart_ar,
   output logic                   uart_arvalid,
   input  logic                   uart_arready,
   input  uart_buf_pkg::rd_data_t uart_r,
   input  logic                   uart_rvalid,
   output logic                   uart_rready
);
   localparam logic [1:0] own_none = 2'd0;
   localparam logic [1:0] own_cpu  = 2'd1;
   localparam logic [1:0] own_poll = 2'd2;

   logic [1:0] owner;
   logic       sel_cpu;
   logic       sel_poll;

   // cpu takes any free slot
   assign sel_cpu  = (owner == own_cpu) || ((owner == own_none) && cpu_req_valid);
   assign sel_poll = (owner == own_poll) ||
                     ((owner == own_none) && !cpu_req_valid && poll_req_valid);

   assign uart_ar        = sel_poll ? poll_req : cpu_req;
   assign uart_arvalid   = (sel_cpu && cpu_req_valid) || (sel_poll && poll_req_valid);
   assign cpu_req_ready  = sel_cpu && uart_arready;
   assign poll_req_ready = sel_poll && uart_arready;

   assign cpu_rsp        = uart_r;
   assign poll_rsp       = uart_r;
   assign cpu_rsp_valid  = uart_rvalid && (owner == own_cpu);
   assign poll_rsp_valid = uart_rvalid && (owner == own_poll);
   assign uart_rready    = ((owner == own_cpu) && cpu_rsp_ready) ||
                           ((owner == own_poll) && poll_rsp_ready);

   always_ff @(posedge clk) begin
      if (rstn) begin
         owner <= own_none;
      end else if (owner == own_none) begin
         if (uart_arvalid && uart_arready) begin
            owner <= sel_poll ? own_poll : own_cpu;
         end
      end else if (uart_rvalid && uart_rready) begin
         owner <= own_none;
      end
   end

   // a pending reply always has someone to go back to
   a_reply_owned: assert property (@(posedge clk) disable iff (rstn)
      uart_rvalid |-> (owner != own_none));

endmodule

//--- uart_buffer/cpu_read_port.sv
module cpu_read_port (
   input  logic                   clk,
   input  logic                   rstn,
   input  uart_buf_pkg::rd_addr_t cpu_ar,
   input  logic                   cpu_arvalid,
   output logic                   cpu_arready,
   output uart_buf_pkg::rd_data_t cpu_r,
   output logic                   cpu_rvalid,
   input  logic                   cpu_rready,
   output uart_buf_pkg::rd_addr_t req,
   output logic                   req_valid,
   input  logic                   req_ready,
   input  uart_buf_pkg::rd_data_t rsp,
   input  logic                   rsp_valid,
   output logic                   rsp_ready,
   input  logic                   empty,
   input  logic [7:0]             head_byte,
   output logic                   pop_en,
   output logic                   busy
);
   localparam logic [1:0] st_idle     = 2'd0;
   localparam logic [1:0] st_fwd_addr = 2'd1;
   localparam logic [1:0] st_fwd_data = 2'd2;
   localparam logic [1:0] st_reply    = 2'd3;

   logic [1:0]               state;
   logic                     ar_hit;
   logic                     late_hit;
   uart_buf_pkg::uart_word_u merged;

   // new rx read with data already in the store
   assign ar_hit = (state == st_idle) && cpu_arvalid &&
                   (cpu_ar.addr == uart_buf_pkg::addr_rx) && !empty;

   // an in-flight poll may land a byte first, take it from the store to keep order
   assign late_hit = (state == st_fwd_addr) && (req.addr == uart_buf_pkg::addr_rx) && !empty;

   assign pop_en      = ar_hit || late_hit;
   assign cpu_arready = (state == st_idle);
   assign cpu_rvalid  = (state == st_reply);
   assign req_valid   = (state == st_fwd_addr) && !late_hit;
   assign rsp_ready   = (state == st_fwd_data);
   assign busy        = (state != st_idle);

   // status reply also reports bytes held here
   always_comb begin
      merged = rsp.data;
      if (req.addr == uart_buf_pkg::addr_stat) begin
         merged.stat.rx_valid = merged.stat.rx_valid | !empty;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (cpu_arvalid) begin
                  state <= ar_hit ? st_reply : st_fwd_addr;
               end
            end
            st_fwd_addr: begin
               if (late_hit) begin
                  state <= st_reply;
               end else if (req_ready) begin
                  state <= st_fwd_data;
               end
            end
            st_fwd_data: begin
               if (rsp_valid) begin
                  state <= st_reply;
               end
            end
            default: begin
               if (cpu_rready) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // payload
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (cpu_arready && cpu_arvalid) begin
         req <= cpu_ar;
      end
      if (pop_en) begin
         cpu_r <= {24'h000000, head_byte, uart_buf_pkg::resp_okay};
      end else if (rsp_ready && rsp_valid) begin
         cpu_r <= {merged, rsp.resp};
      end
   end

   a_rvalid_hold: assert property (@(posedge clk) disable iff (rstn)
      cpu_rvalid && !cpu_rready |=> cpu_rvalid && $stable(cpu_r));

endmodule

//--- uart_buffer/rx_poller.sv
module rx_poller (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   full,
   input  logic                   cpu_busy,
   output uart_buf_pkg::rd_addr_t req,
   output logic                   req_valid,
   input  logic                   req_ready,
   input  uart_buf_pkg::rd_data_t rsp,
   input  logic                   rsp_valid,
   output logic                   rsp_ready,
   output logic                   push_en,
   output logic [7:0]             push_byte
);
   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_addr = 2'd1;
   localparam logic [1:0] st_data = 2'd2;

   logic [1:0]               state;
   uart_buf_pkg::uart_word_u word;

   assign word      = rsp.data;
   assign req       = {uart_buf_pkg::addr_rx, 3'b000};
   assign req_valid = (state == st_addr);
   assign rsp_ready = (state == st_data);

   // push lands on the R transfer, so full is current by the next idle
   assign push_en   = rsp_ready && rsp_valid && (rsp.resp == uart_buf_pkg::resp_okay);
   assign push_byte = word.rx.data;

   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (!full && !cpu_busy) begin
                  state <= st_addr;
               end
            end
            st_addr: begin
               if (req_ready) begin
                  state <= st_data;
               end
            end
            st_data: begin
               if (rsp_valid) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   a_req_hold: assert property (@(posedge clk) disable iff (rstn)
      req_valid && !req_ready |=> req_valid);

endmodule

//--- uart_buffer/rx_byte_store.sv
module rx_byte_store #(
   parameter int store_depth = 16
) (
   input  logic       clk,
   input  logic       rstn,
   input  logic       push_en,
   input  logic       pop_en,
   input  logic [7:0] push_byte,
   output logic [7:0] head_byte,
   output logic       empty,
   output logic       full
);
   localparam int ptr_w = $clog2(store_depth);
   localparam int cnt_w = $clog2(store_depth + 1);

   logic [7:0]       mem [store_depth];
   logic [ptr_w-1:0] head;
   logic [ptr_w-1:0] tail;
   logic [cnt_w-1:0] count;

   assign head_byte = mem[head];
   assign empty     = (count == '0);
   assign full      = (count == cnt_w'(store_depth));

   always_ff @(posedge clk) begin
      if (push_en) begin
         mem[tail] <= push_byte;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         // pointers wrap by compare so any depth works
         if (push_en) begin
            tail <= (tail == ptr_w'(store_depth - 1)) ? '0 : tail + 1'b1;
         end
         if (pop_en) begin
            head <= (head == ptr_w'(store_depth - 1)) ? '0 : head + 1'b1;
         end
         case ({push_en, pop_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // poller checks full only before it issues a read
   a_no_push_full: assert property (@(posedge clk) disable iff (rstn)
      push_en |-> !full);
   a_no_pop_empty: assert property (@(posedge clk) disable iff (rstn)
      pop_en |-> !empty);

endmodule

//--- common/uart_buf_pkg.sv
package uart_buf_pkg;

   //////////////////////////////////////////////////
   // bus channels
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [3:0] addr;
      logic [2:0] prot;
   } rd_addr_t;

   typedef struct packed {
      logic [31:0] data;
      logic [1:0]  resp;
   } rd_data_t;

   typedef struct packed {
      logic [3:0]  addr;
      logic [2:0]  prot;
      logic [31:0] data;
      logic [3:0]  strb;
   } wr_req_t;

   //////////////////////////////////////////////////
   // uart read word, two decodings
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [23:0] pad;
      logic [7:0]  data;
   } rx_view_t;

   typedef struct packed {
      logic [23:0] pad;
      logic        parity_err;
      logic        frame_err;
      logic        overrun;
      logic        intr_en;
      logic        tx_full;
      logic        tx_empty;
      logic        rx_full;
      logic        rx_valid;
   } stat_view_t;

   typedef union packed {
      rx_view_t   rx;
      stat_view_t stat;
   } uart_word_u;

   // register map
   localparam logic [3:0] addr_rx   = 4'h0;
   localparam logic [3:0] addr_tx   = 4'h4;
   localparam logic [3:0] addr_stat = 4'h8;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

endpackage
